// File: project.f
+incdir+verilog
verilog/video_pkg.sv
verilog/bus_pkg.sv
verilog/video_timing.sv
verilog/beam_scanout.sv
verilog/frame_memory.sv
verilog/bus_decoder.sv
verilog/video_top.sv
tb/video_checker.sv
tb/video_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= video_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/video_tb.sv
`default_nettype none

`include "video_defs.svh"

module video_tb;

	localparam int FRAME_CYCLES = `LINE_CYCLES * `FRAME_LINES;
	localparam int MAX_SHOWN = 40;

	logic clock;
	logic reset_i;
	bus_pkg::bus_req_t bus_req;
	bus_pkg::bus_rsp_t bus_rsp;
	video_pkg::video_out_t video;

	video_pkg::rgb666_t ref_frame [`FRAME_WORDS];
	int edges;
	logic exp_ack;
	logic [23:0] exp_rdata;
	int errors [1:5];
	int shown;
	int h_sync_cycles;
	int v_sync_cycles;
	int current_test;
	logic [31:0] rng;

	video_top u_dut (
		.clock(clock),
		.reset_i(reset_i),
		.bus_req_i(bus_req),
		.bus_rsp_o(bus_rsp),
		.video_o(video)
	);

	bind video_top video_checker u_checker (
		.clock(clock),
		.reset_i(reset_i),
		.bus_req_i(bus_req_i),
		.bus_rsp_i(bus_rsp_o),
		.video_i(video_o)
	);

	always #5 clock = ~clock;

	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] s;
		s = state ^ (state << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic int pos_x(input int p);
		return p % `LINE_CYCLES;
	endfunction

	function automatic int pos_y(input int p);
		return (p / `LINE_CYCLES) % `FRAME_LINES;
	endfunction

	function automatic video_pkg::rgb666_t expected_color(input int x, input int y);
		if (x >= `FRAME_W || y >= `FRAME_H) begin
			return '0;
		end
		if (x == 0 || y == 0 || x == `FRAME_W - 1 || y == `FRAME_H - 1) begin
			return {`BORDER_COLOR, `BORDER_COLOR, `BORDER_COLOR};
		end
		return ref_frame[`FRAME_WORDS_W * (y / `SCALE) + x / `SCALE];
	endfunction

	// Expected read data one cycle after a request
	function automatic logic [23:0] expected_read(input bus_pkg::bus_req_t req,
			input logic v_blank);
		video_pkg::rgb666_t c;
		if (!req.strobe || req.write) begin
			return '0;
		end
		if (req.addr[`FRAME_SEL_BIT]) begin
			c = ref_frame[req.addr[`FRAME_ADDR_BITS-1:0]];
			return {2'b00, c.red, 2'b00, c.green, 2'b00, c.blue};
		end
		if (req.addr == `BUS_ADDR_BITS'(`ADDR_V_BLANK)) begin
			return {23'd0, v_blank};
		end
		return '0;
	endfunction

	task automatic report_mismatch(input int test, input string name,
			input logic [23:0] expected, input logic [23:0] actual);
		errors[test] = errors[test] + 1;
		if (shown < MAX_SHOWN) begin
			$display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, expected, actual);
		end else if (shown == MAX_SHOWN) begin
			$display("More mismatches follow, not shown");
		end
		shown = shown + 1;
	endtask

	task automatic report_test(input int test, input string name);
		$display("Test %0d %s: %s with %0d errors", test, name,
			errors[test] == 0 ? "ok" : "failed", errors[test]);
	endtask

	task automatic bus_access(input logic [14:0] addr, input logic [23:0] data,
			input logic [2:0] select, input logic write);
		bus_req.addr = addr;
		bus_req.wdata.raw = data;
		bus_req.select = select;
		bus_req.write = write;
		bus_req.strobe = 1'b1;
		@(negedge clock);
	endtask

	task automatic bus_idle();
		bus_req = '0;
		@(negedge clock);
		@(negedge clock);
	endtask

	task automatic wait_for_edges(input int count);
		while (edges < count) begin
			@(negedge clock);
		end
	endtask

	task automatic status_read(input logic expected_bit);
		bus_access(`BUS_ADDR_BITS'(`ADDR_V_BLANK), '0, 3'b000, 1'b0);
		bus_req = '0;
		if (bus_rsp.rdata.raw !== {23'd0, expected_bit}) begin
			report_mismatch(4, "bus_rsp_o.rdata", {23'd0, expected_bit}, bus_rsp.rdata.raw);
		end
	endtask

	// Reference frame follows the bus at the clock edge that takes each request
	always @(posedge clock) begin
		logic v_blank_now;
		logic [13:0] a;
		v_blank_now = edges >= 1 && pos_y(edges - 1) >= `FRAME_H;
		a = bus_req.addr[13:0];
		if (reset_i) begin
			edges <= 0;
			exp_ack <= 1'b0;
			exp_rdata <= '0;
		end else begin
			edges <= edges + 1;
			exp_ack <= bus_req.strobe;
			exp_rdata <= expected_read(bus_req, v_blank_now);
			if (bus_req.strobe && bus_req.write && bus_req.addr[`FRAME_SEL_BIT]) begin
				if (bus_req.select[2]) begin
					ref_frame[a].red = bus_req.wdata.raw[21:16];
				end
				if (bus_req.select[1]) begin
					ref_frame[a].green = bus_req.wdata.raw[13:8];
				end
				if (bus_req.select[0]) begin
					ref_frame[a].blue = bus_req.wdata.raw[5:0];
				end
			end
		end
	end

	always @(negedge clock) begin
		video_pkg::video_out_t exp_video;
		logic color_known;
		int p;
		int x;
		int y;
		exp_video = '0;
		color_known = 1'b1;
		if (!reset_i && edges >= 1) begin
			p = edges - 1;
			x = pos_x(p);
			y = pos_y(p);
			exp_video.blank[0] = x >= `FRAME_W;
			exp_video.blank[1] = y >= `FRAME_H;
			exp_video.sync[0] = x >= 656 && x < 752;
			exp_video.sync[1] = y >= 450 && y < 452;
			exp_video.color = expected_color(x, y);
			// Stored words are only compared over the second frame
			if (x > 0 && x < `FRAME_W - 1 && y > 0 && y < `FRAME_H - 1) begin
				color_known = p / FRAME_CYCLES == 1;
			end
			if (p < FRAME_CYCLES) begin
				h_sync_cycles = h_sync_cycles + int'(video.sync[0]);
				v_sync_cycles = v_sync_cycles + int'(video.sync[1]);
			end
		end
		if (video.blank !== exp_video.blank) begin
			report_mismatch(1, "video_o.blank", 24'(exp_video.blank), 24'(video.blank));
		end
		if (video.sync !== exp_video.sync) begin
			report_mismatch(1, "video_o.sync", 24'(exp_video.sync), 24'(video.sync));
		end
		if (color_known && video.color !== exp_video.color) begin
			report_mismatch(3, "video_o.color", 24'(exp_video.color), 24'(video.color));
		end
		if (bus_rsp.ack !== exp_ack) begin
			report_mismatch(current_test, "bus_rsp_o.ack", 24'(exp_ack), 24'(bus_rsp.ack));
		end
		if (bus_rsp.rdata.raw !== exp_rdata) begin
			report_mismatch(current_test, "bus_rsp_o.rdata", exp_rdata, bus_rsp.rdata.raw);
		end
	end

	initial begin
		#((3 * FRAME_CYCLES + 20000) * 10);
		$display("Watchdog expired before the tests finished");
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int a;
		int touched [$];
		int total;
		clock = 1'b0;
		reset_i = 1'b1;
		bus_req = '0;
		rng = 32'd11026;
		shown = 0;
		h_sync_cycles = 0;
		v_sync_cycles = 0;
		current_test = 2;
		foreach (errors[t]) begin
			errors[t] = 0;
		end
		repeat (5) @(negedge clock);
		reset_i = 1'b0;

		// Fill every word, then overwrite random channels
		for (a = 0; a < `FRAME_WORDS; a++) begin
			rng = xorshift32(rng);
			bus_access({1'b1, 14'(a)}, rng[23:0], 3'b111, 1'b1);
		end
		repeat (300) begin
			rng = xorshift32(rng);
			a = int'(rng[31:8]) % `FRAME_WORDS;
			touched.push_back(a);
			rng = xorshift32(rng);
			bus_access({1'b1, 14'(a)}, rng[23:0], rng[26:24], 1'b1);
		end
		foreach (touched[k]) begin
			bus_access({1'b1, 14'(touched[k])}, '0, 3'b000, 1'b0);
		end
		bus_idle();
		report_test(2, "frame write and read");

		current_test = 5;
		repeat (40) begin
			rng = xorshift32(rng);
			a = int'(rng[13:0]) == `ADDR_V_BLANK ? `ADDR_V_BLANK + 1 : int'(rng[13:0]);
			bus_access({1'b0, 14'(a)}, rng[31:8], 3'b111, 1'b1);
			bus_access({1'b0, 14'(a)}, '0, 3'b000, 1'b0);
			if (a < `FRAME_WORDS) begin
				bus_access({1'b1, 14'(a)}, '0, 3'b000, 1'b0);
			end
		end
		bus_idle();
		report_test(5, "other addresses");

		wait_for_edges(FRAME_CYCLES + 1);
		if (h_sync_cycles != `H_SYNC * `FRAME_LINES) begin
			$display("Horizontal sync was high for %0d cycles of a frame", h_sync_cycles);
			errors[1] = errors[1] + 1;
		end
		if (v_sync_cycles != `V_SYNC * `LINE_CYCLES) begin
			$display("Vertical sync was high for %0d cycles of a frame", v_sync_cycles);
			errors[1] = errors[1] + 1;
		end
		report_test(1, "sync and blank geometry");

		current_test = 4;
		wait_for_edges(FRAME_CYCLES + 200 * `LINE_CYCLES + 320 + 1);
		status_read(1'b0);
		wait_for_edges(FRAME_CYCLES + 450 * `LINE_CYCLES + 100 + 1);
		status_read(1'b1);
		bus_idle();
		report_test(4, "status read");

		wait_for_edges(2 * FRAME_CYCLES + 2);
		report_test(3, "scan-out");

		total = errors[1] + errors[2] + errors[3] + errors[4] + errors[5];
		$display("Summary: 5 tests, %0d errors in total", total);
		if (total == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/video_checker.sv
`default_nettype none

module video_checker (
	input wire clock,
	input wire reset_i,
	input wire bus_pkg::bus_req_t bus_req_i,
	input wire bus_pkg::bus_rsp_t bus_rsp_i,
	input wire video_pkg::video_out_t video_i
);

	// Ack exactly one cycle after each strobe
	ack_after_strobe: assert property (@(posedge clock) disable iff (reset_i)
		bus_req_i.strobe |=> bus_rsp_i.ack)
		else $error("ack missing one cycle after a strobe");

	no_stray_ack: assert property (@(posedge clock) disable iff (reset_i)
		!bus_req_i.strobe |=> !bus_rsp_i.ack)
		else $error("ack without a strobe on the cycle before");

	blank_is_black: assert property (@(posedge clock) disable iff (reset_i)
		video_i.blank != 2'b00 |-> video_i.color == '0)
		else $error("colour is not zero while blanked");

	// Sync pulses live inside the blanking interval
	no_sync_when_visible: assert property (@(posedge clock) disable iff (reset_i)
		video_i.blank == 2'b00 |-> video_i.sync == 2'b00)
		else $error("sync is high on a visible pixel");

endmodule

`default_nettype wire

// File: verilog/video_top.sv
`default_nettype none

`include "video_defs.svh"

module video_top (
	input wire clock,
	input wire reset_i,
	input wire bus_pkg::bus_req_t bus_req_i,
	output bus_pkg::bus_rsp_t bus_rsp_o,
	output video_pkg::video_out_t video_o
);

	video_pkg::beam_pos_t beam;
	logic [1:0] blank;
	logic [1:0] sync;

	logic [`FRAME_ADDR_BITS-1:0] beam_addr;
	video_pkg::rgb666_t beam_pixel;

	logic frame_strobe;
	logic frame_write;
	logic [2:0] frame_select;
	logic [`FRAME_ADDR_BITS-1:0] frame_addr;
	video_pkg::rgb666_t frame_wpixel;
	video_pkg::rgb666_t frame_rpixel;

	video_timing u_timing (
		.clock(clock),
		.reset_i(reset_i),
		.beam_o(beam),
		.blank_o(blank),
		.sync_o(sync)
	);

	beam_scanout u_scanout (
		.clock(clock),
		.reset_i(reset_i),
		.beam_i(beam),
		.blank_i(blank),
		.sync_i(sync),
		.frame_addr_o(beam_addr),
		.frame_pixel_i(beam_pixel),
		.video_o(video_o)
	);

	frame_memory u_frame (
		.clock(clock),
		.beam_addr_i(beam_addr),
		.beam_pixel_o(beam_pixel),
		.bus_strobe_i(frame_strobe),
		.bus_write_i(frame_write),
		.bus_select_i(frame_select),
		.bus_addr_i(frame_addr),
		.bus_pixel_i(frame_wpixel),
		.bus_pixel_o(frame_rpixel)
	);

	// Status word reads the registered vertical blank
	bus_decoder u_decoder (
		.clock(clock),
		.reset_i(reset_i),
		.bus_req_i(bus_req_i),
		.bus_rsp_o(bus_rsp_o),
		.v_blank_i(video_o.blank[1]),
		.frame_strobe_o(frame_strobe),
		.frame_write_o(frame_write),
		.frame_select_o(frame_select),
		.frame_addr_o(frame_addr),
		.frame_pixel_o(frame_wpixel),
		.frame_pixel_i(frame_rpixel)
	);

endmodule

`default_nettype wire

// File: verilog/bus_decoder.sv
`default_nettype none

`include "video_defs.svh"

module bus_decoder (
	input wire clock,
	input wire reset_i,
	input wire bus_pkg::bus_req_t bus_req_i,
	output bus_pkg::bus_rsp_t bus_rsp_o,
	input wire v_blank_i,

	// Frame buffer port
	output logic frame_strobe_o,
	output logic frame_write_o,
	output logic [2:0] frame_select_o,
	output logic [`FRAME_ADDR_BITS-1:0] frame_addr_o,
	output video_pkg::rgb666_t frame_pixel_o,
	input wire video_pkg::rgb666_t frame_pixel_i
);

	logic to_frame;
	logic to_v_blank;
	logic ack_q;
	logic from_frame;
	logic from_v_blank;
	logic v_blank_q;
	bus_pkg::bus_word_u frame_word;
	bus_pkg::bus_word_u status_word;

	assign to_frame = bus_req_i.addr[`FRAME_SEL_BIT];
	assign to_v_blank = bus_req_i.addr == `BUS_ADDR_BITS'(`ADDR_V_BLANK);

	assign frame_strobe_o = bus_req_i.strobe && to_frame;
	assign frame_write_o = bus_req_i.write;
	assign frame_select_o = bus_req_i.select;
	assign frame_addr_o = bus_req_i.addr[`FRAME_ADDR_BITS-1:0];

	assign frame_pixel_o.red = bus_req_i.wdata.bytes.red.channel;
	assign frame_pixel_o.green = bus_req_i.wdata.bytes.green.channel;
	assign frame_pixel_o.blue = bus_req_i.wdata.bytes.blue.channel;

	// Source of next cycle's read data, cleared when idle
	always_ff @(posedge clock) begin
		if (reset_i) begin
			ack_q <= 1'b0;
			from_frame <= 1'b0;
			from_v_blank <= 1'b0;
		end else begin
			ack_q <= bus_req_i.strobe;
			from_frame <= bus_req_i.strobe && to_frame && !bus_req_i.write;
			from_v_blank <= bus_req_i.strobe && to_v_blank && !bus_req_i.write;
		end
	end

	always_ff @(posedge clock) begin
		if (bus_req_i.strobe) begin
			v_blank_q <= v_blank_i;
		end
	end

	always_comb begin
		frame_word = '0;
		frame_word.bytes.red.channel = frame_pixel_i.red;
		frame_word.bytes.green.channel = frame_pixel_i.green;
		frame_word.bytes.blue.channel = frame_pixel_i.blue;

		status_word = '0;
		status_word.raw[0] = v_blank_q;

		bus_rsp_o.ack = ack_q;
		bus_rsp_o.rdata.raw = (from_frame ? frame_word.raw : 24'd0)
			| (from_v_blank ? status_word.raw : 24'd0);
	end

endmodule

`default_nettype wire

// File: verilog/frame_memory.sv
`default_nettype none

`include "video_defs.svh"

module frame_memory (
	input wire clock,

	// Beam side, read only
	input wire [`FRAME_ADDR_BITS-1:0] beam_addr_i,
	output video_pkg::rgb666_t beam_pixel_o,

	// Bus side
	input wire bus_strobe_i,
	input wire bus_write_i,
	input wire [2:0] bus_select_i,
	input wire [`FRAME_ADDR_BITS-1:0] bus_addr_i,
	input wire video_pkg::rgb666_t bus_pixel_i,
	output video_pkg::rgb666_t bus_pixel_o
);

	video_pkg::rgb666_t mem [`FRAME_WORDS];

	always_ff @(posedge clock) begin
		beam_pixel_o <= mem[beam_addr_i];
	end

	// Per channel write enables
	always_ff @(posedge clock) begin
		if (bus_strobe_i) begin
			if (bus_write_i) begin
				if (bus_select_i[2]) begin
					mem[bus_addr_i].red <= bus_pixel_i.red;
				end
				if (bus_select_i[1]) begin
					mem[bus_addr_i].green <= bus_pixel_i.green;
				end
				if (bus_select_i[0]) begin
					mem[bus_addr_i].blue <= bus_pixel_i.blue;
				end
			end else begin
				bus_pixel_o <= mem[bus_addr_i];
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/beam_scanout.sv
`default_nettype none

`include "video_defs.svh"

module beam_scanout (
	input wire clock,
	input wire reset_i,
	input wire video_pkg::beam_pos_t beam_i,
	input wire [1:0] blank_i,
	input wire [1:0] sync_i,
	output logic [`FRAME_ADDR_BITS-1:0] frame_addr_o,
	input wire video_pkg::rgb666_t frame_pixel_i,
	output video_pkg::video_out_t video_o
);

	logic       border;
	logic       border_q;
	logic [1:0] blank_q;
	logic [1:0] sync_q;
	logic       live_q;

	// Word address of the 4x4 block under the beam
	assign frame_addr_o = `FRAME_ADDR_BITS'(
		`FRAME_WORDS_W * (beam_i.y / `SCALE) + beam_i.x / `SCALE);

	assign border = beam_i.x == '0
		|| beam_i.y == '0
		|| beam_i.x == `X_BITS'(`FRAME_W - 1)
		|| beam_i.y == `Y_BITS'(`FRAME_H - 1);

	// Aligned with the one cycle frame read
	always_ff @(posedge clock) begin
		if (reset_i) begin
			blank_q <= '0;
			sync_q <= '0;
			border_q <= 1'b0;
			live_q <= 1'b0;
		end else begin
			blank_q <= blank_i;
			sync_q <= sync_i;
			border_q <= border;
			live_q <= 1'b1;
		end
	end

	always_comb begin
		video_o.blank = blank_q;
		video_o.sync = sync_q;
		if (!live_q || blank_q != 2'b00) begin
			video_o.color = '0;
		end else if (border_q) begin
			video_o.color.red = `BORDER_COLOR;
			video_o.color.green = `BORDER_COLOR;
			video_o.color.blue = `BORDER_COLOR;
		end else begin
			video_o.color = frame_pixel_i;
		end
	end

endmodule

`default_nettype wire

// File: verilog/video_timing.sv
`default_nettype none

`include "video_defs.svh"

module video_timing (
	input wire clock,
	input wire reset_i,
	output video_pkg::beam_pos_t beam_o,
	output logic [1:0] blank_o,
	output logic [1:0] sync_o
);

	logic x_last;
	logic y_last;

	assign x_last = beam_o.x == `X_BITS'(`LINE_CYCLES - 1);
	assign y_last = beam_o.y == `Y_BITS'(`FRAME_LINES - 1);

	always_ff @(posedge clock) begin
		if (reset_i) begin
			beam_o <= '0;
		end else if (x_last) begin
			beam_o.x <= '0;
			if (y_last) begin
				beam_o.y <= '0;
			end else begin
				beam_o.y <= beam_o.y + 1'b1;
			end
		end else begin
			beam_o.x <= beam_o.x + 1'b1;
		end
	end

	assign blank_o[0] = beam_o.x >= `X_BITS'(`FRAME_W);
	assign blank_o[1] = beam_o.y >= `Y_BITS'(`FRAME_H);

	// Sync pulses sit after the front porch
	assign sync_o[0] = beam_o.x >= `X_BITS'(`FRAME_W + `H_FP)
		&& beam_o.x < `X_BITS'(`FRAME_W + `H_FP + `H_SYNC);
	assign sync_o[1] = beam_o.y >= `Y_BITS'(`FRAME_H + `V_PAD + `V_FP)
		&& beam_o.y < `Y_BITS'(`FRAME_H + `V_PAD + `V_FP + `V_SYNC);

endmodule

`default_nettype wire

// File: verilog/bus_pkg.sv
`default_nettype none

`include "video_defs.svh"

package bus_pkg;

	// Colour channel in the low bits of a byte lane
	typedef struct packed {
		logic [1:0] unused;
		logic [5:0] channel;
	} bus_byte_t;

	typedef struct packed {
		bus_byte_t red;
		bus_byte_t green;
		bus_byte_t blue;
	} bus_bytes_t;

	typedef union packed {
		logic [23:0] raw;
		bus_bytes_t  bytes;
	} bus_word_u;

	// Select bit 2 is red, bit 1 green, bit 0 blue
	typedef struct packed {
		logic [`BUS_ADDR_BITS-1:0] addr;
		bus_word_u                 wdata;
		logic [2:0]                select;
		logic                      write;
		logic                      strobe;
	} bus_req_t;

	typedef struct packed {
		bus_word_u rdata;
		logic      ack;
	} bus_rsp_t;

endpackage

`default_nettype wire

// File: verilog/video_pkg.sv
`default_nettype none

`include "video_defs.svh"

package video_pkg;

	typedef struct packed {
		logic [5:0] red;
		logic [5:0] green;
		logic [5:0] blue;
	} rgb666_t;

	typedef struct packed {
		logic [`X_BITS-1:0] x;
		logic [`Y_BITS-1:0] y;
	} beam_pos_t;

	// Blank and sync bit 0 is horizontal, bit 1 vertical
	typedef struct packed {
		rgb666_t    color;
		logic [1:0] blank;
		logic [1:0] sync;
	} video_out_t;

endpackage

`default_nettype wire

// File: verilog/video_defs.svh
`ifndef VIDEO_DEFS_SVH
`define VIDEO_DEFS_SVH

// Visible area in screen pixels
`define FRAME_W 640
`define FRAME_H 400

// One stored word covers a SCALE by SCALE block
`define SCALE 4
`define FRAME_WORDS_W (`FRAME_W / `SCALE)
`define FRAME_WORDS_H (`FRAME_H / `SCALE)
`define FRAME_WORDS (`FRAME_WORDS_W * `FRAME_WORDS_H)
`define FRAME_ADDR_BITS 14

// Horizontal porches
`define H_FP 16
`define H_SYNC 96
`define H_BP 48

// Vertical padding and porches, padding on both sides of the picture
`define V_PAD 40
`define V_FP 10
`define V_SYNC 2
`define V_BP 33

`define LINE_CYCLES (`FRAME_W + `H_FP + `H_SYNC + `H_BP)
`define FRAME_LINES (`FRAME_H + `V_PAD + `V_FP + `V_SYNC + `V_BP + `V_PAD)

`define X_BITS 10
`define Y_BITS 10

// Bus address layout
`define BUS_ADDR_BITS 15
`define FRAME_SEL_BIT 14
`define ADDR_V_BLANK 16

`define BORDER_COLOR 6'b011111

`endif
